// ==== Makefile ====
TOP  := tb_top
SIM  := obj_dir/V$(TOP)
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a source changes
$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

# Exit status of the binary is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== dv/axil_checker.sv ====
`timescale 1ns/1ps

module axil_checker import axil_pkg::*; (
    input logic     clk50,
    input logic     rst,
    input logic     pause_req,
    input logic     pause_ack,
    input logic     aw_valid,
    input logic     aw_ready,
    input axil_aw_t aw,
    input logic     w_valid,
    input logic     w_ready,
    input axil_w_t  w,
    input logic     b_valid,
    input logic     b_ready,
    input axil_b_t  b,
    input logic     ar_valid,
    input logic     ar_ready,
    input axil_ar_t ar,
    input logic     r_valid,
    input logic     r_ready,
    input axil_r_t  r
);

    // ##################################################################
    // Valid and payload hold until the handshake
    // ##################################################################

    assert property (@(posedge clk50) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW valid or payload changed before its handshake");

    assert property (@(posedge clk50) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W valid or payload changed before its handshake");

    assert property (@(posedge clk50) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("B valid or payload changed before its handshake");

    assert property (@(posedge clk50) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("AR valid or payload changed before its handshake");

    assert property (@(posedge clk50) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R valid or payload changed before its handshake");

    // Responses clear on the first edge of reset
    assert property (@(posedge clk50) rst |=> !b_valid && !r_valid)
        else $error("B or R valid while reset is held");

    assert property (@(posedge clk50) pause_ack |-> $past(pause_req))
        else $error("pause_ack high without a pause request");

endmodule

bind axil_ram axil_checker u_axil_checker (.*);

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk50
);

    localparam time HALF_PERIOD = 10ns;  // 50 MHz board clock

    initial clk50 = 1'b0;

    always #(HALF_PERIOD) clk50 = ~clk50;

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import board_pkg::*; ();

    localparam int RESET_HOLD = 16;   // Cycles with cpu_resetn low
    localparam int BOOT_LIMIT = 400;
    localparam int WAIT_LIMIT = 100;

    logic       clk50;
    logic       cpu_resetn;
    logic       btnc;
    logic       btnd;
    logic [7:0] sw;
    logic [7:0] led;
    logic       boot_done;
    logic       pause_ack;
    logic       view_busy;
    integer     seed;

    tb_clk_gen u_clk_gen (
        .clk50 (clk50)
    );

    nexys_boot_top DUT (
        .clk50      (clk50),
        .cpu_resetn (cpu_resetn),
        .btnc       (btnc),
        .btnd       (btnd),
        .sw         (sw),
        .led        (led),
        .boot_done  (boot_done),
        .pause_ack  (pause_ack),
        .view_busy  (view_busy)
    );

    // ######################################################################
    // Helpers
    // ######################################################################

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("tests failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic next_cycle;
        @(posedge clk50);
        #2;  // Inputs change away from the edge
    endtask

    task automatic wait_boot_done;
        int n;
        n = 0;
        while (!boot_done && n < BOOT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!boot_done) report_timeout("boot_done to rise");
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (view_busy !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (view_busy !== level) report_timeout("view_busy to change");
    endtask

    task automatic wait_pause_ack(input logic level);
        int n;
        n = 0;
        while (pause_ack !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (pause_ack !== level) report_timeout("pause_ack to change");
    endtask

    // Press btnd for one read and compare the LEDs with the image byte
    task automatic read_and_check(input int word, input int sel);
        sw   = {2'b00, 2'(sel), 4'(word)};
        btnd = 1'b1;
        wait_busy(1'b1);
        btnd = 1'b0;
        wait_busy(1'b0);
        check_value("led", 32'(led), 32'(boot_byte(word, sel)));
        next_cycle();
    endtask

    // ######################################################################
    // Directed tests
    // ######################################################################

    task automatic reset_state;
        cpu_resetn = 1'b0;
        repeat (RESET_HOLD) next_cycle();
        check_value("led", 32'(led), 32'd0);
        check_value("boot_done", 32'(boot_done), 32'd0);
        check_value("pause_ack", 32'(pause_ack), 32'd0);
        check_value("view_busy", 32'(view_busy), 32'd0);
        cpu_resetn = 1'b1;
        wait_boot_done();
    endtask

    task automatic readback_all;
        for (int i = 0; i < BOOT_WORDS; i++) begin
            for (int k = 0; k < 4; k++) begin
                read_and_check(i, k);
            end
        end
    endtask

    task automatic random_reads;
        integer v;
        repeat (40) begin
            v = $random(seed);
            read_and_check(int'(v[3:0]), int'(v[5:4]));
        end
    endtask

    task automatic pause_read;
        logic [7:0] old_led;
        read_and_check(0, 0);
        old_led = led;
        btnc    = 1'b1;
        wait_pause_ack(1'b1);
        sw   = {2'b00, 2'd2, 4'd9};
        btnd = 1'b1;
        wait_busy(1'b1);
        btnd = 1'b0;
        repeat (20) begin  // Read sits in the AR skid
            next_cycle();
            check_value("view_busy", 32'(view_busy), 32'd1);
            check_value("led", 32'(led), 32'(old_led));
        end
        btnc = 1'b0;
        wait_pause_ack(1'b0);
        wait_busy(1'b0);
        check_value("led", 32'(led), 32'(boot_byte(9, 2)));
        next_cycle();
    endtask

    task automatic reset_mid_run;
        read_and_check(3, 1);
        read_and_check(12, 3);
        cpu_resetn = 1'b0;
        repeat (3) next_cycle();
        check_value("led", 32'(led), 32'd0);
        check_value("boot_done", 32'(boot_done), 32'd0);
        repeat (RESET_HOLD - 3) next_cycle();
        cpu_resetn = 1'b1;
        wait_boot_done();
        read_and_check(0, 0);
        read_and_check(7, 3);
        read_and_check(15, 2);
        read_and_check(10, 1);
    endtask

    initial begin
        seed       = 32'h09dd9935;
        cpu_resetn = 1'b0;
        btnc       = 1'b0;
        btnd       = 1'b0;
        sw         = '0;

        reset_state();
        readback_all();
        random_reads();
        pause_read();
        reset_mid_run();

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== hw/axil_pkg.sv ====
package axil_pkg;
    import board_pkg::*;

    // ######################################################################
    // Channel payloads, valid and ready travel beside them
    // ######################################################################

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            prot;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [WORD_BYTES-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            prot;
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
    } axil_r_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== hw/axil_ram.sv ====
`timescale 1ns/1ps

module axil_ram import board_pkg::*, axil_pkg::*; (
    input  logic     clk50,
    input  logic     rst,

    input  logic     pause_req,
    output logic     pause_ack,

    input  logic     aw_valid,
    output logic     aw_ready,
    input  axil_aw_t aw,

    input  logic     w_valid,
    output logic     w_ready,
    input  axil_w_t  w,

    output logic     b_valid,
    input  logic     b_ready,
    output axil_b_t  b,

    input  logic     ar_valid,
    output logic     ar_ready,
    input  axil_ar_t ar,

    output logic     r_valid,
    input  logic     r_ready,
    output axil_r_t  r
);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    logic     aw_h_valid;
    logic     w_h_valid;
    logic     ar_h_valid;
    axil_aw_t aw_h;
    axil_w_t  w_h;
    axil_ar_t ar_h;

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  b_valid_q;
    logic                  r_valid_q;
    logic [DATA_WIDTH-1:0] r_data_q;

    // ######################################################################
    // Request skids
    // ######################################################################

    skid_buffer #(.payload_t(axil_aw_t)) aw_skid (
        .clk50     (clk50),
        .rst       (rst),
        .in_valid  (aw_valid),
        .in_ready  (aw_ready),
        .in_data   (aw),
        .out_valid (aw_h_valid),
        .out_ready (wr_fire),
        .out_data  (aw_h)
    );

    skid_buffer #(.payload_t(axil_w_t)) w_skid (
        .clk50     (clk50),
        .rst       (rst),
        .in_valid  (w_valid),
        .in_ready  (w_ready),
        .in_data   (w),
        .out_valid (w_h_valid),
        .out_ready (wr_fire),
        .out_data  (w_h)
    );

    skid_buffer #(.payload_t(axil_ar_t)) ar_skid (
        .clk50     (clk50),
        .rst       (rst),
        .in_valid  (ar_valid),
        .in_ready  (ar_ready),
        .in_data   (ar),
        .out_valid (ar_h_valid),
        .out_ready (rd_fire),
        .out_data  (ar_h)
    );

    // ######################################################################
    // Request service
    // ######################################################################

    // A held response blocks the next request of its kind
    assign wr_fire = aw_h_valid && w_h_valid && (!b_valid_q || b_ready) && !pause_req;
    assign rd_fire = ar_h_valid && (!r_valid_q || r_ready) && !pause_req;

    always_ff @(posedge clk50) begin
        if (wr_fire) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                if (w_h.strb[k]) mem[word_index(aw_h.addr)][8*k +: 8] <= w_h.data[8*k +: 8];
            end
        end
        if (rd_fire) r_data_q <= mem[word_index(ar_h.addr)];
    end

    always_ff @(posedge clk50) begin
        if (rst) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
            pause_ack <= 1'b0;
        end else begin
            if (wr_fire) b_valid_q <= 1'b1;
            else if (b_ready) b_valid_q <= 1'b0;

            if (rd_fire) r_valid_q <= 1'b1;
            else if (r_ready) r_valid_q <= 1'b0;

            // Ack once both response channels have drained
            pause_ack <= pause_req && (pause_ack || (!b_valid_q && !r_valid_q));
        end
    end

    assign b_valid = b_valid_q;
    assign b.resp  = RESP_OKAY;
    assign r_valid = r_valid_q;
    assign r.data  = r_data_q;
    assign r.resp  = RESP_OKAY;

endmodule

// ==== hw/board_pkg.sv ====
package board_pkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int MEM_WORDS    = 256;
    localparam int BOOT_WORDS   = 16;
    localparam int RESET_CYCLES = 16;

    localparam int WORD_BYTES  = DATA_WIDTH / 8;
    localparam int BYTE_OFFSET = $clog2(WORD_BYTES);
    localparam int WORD_BITS   = $clog2(MEM_WORDS);  // RAM index width
    localparam int BOOT_IDX_W  = $clog2(BOOT_WORDS);
    localparam int RESET_CNT_W = $clog2(RESET_CYCLES + 1);

    // Byte address of a word
    function automatic logic [ADDR_WIDTH-1:0] word_addr(input int unsigned idx);
        return ADDR_WIDTH'(idx) << BYTE_OFFSET;
    endfunction

    // Word index taken from the address bits above the byte offset
    function automatic logic [WORD_BITS-1:0] word_index(input logic [ADDR_WIDTH-1:0] addr);
        return addr[BYTE_OFFSET +: WORD_BITS];
    endfunction

    // Boot image content, byte k of word i
    function automatic logic [7:0] boot_byte(input int unsigned word, input int unsigned k);
        return 8'(16 + 4 * word + k);
    endfunction

endpackage

// ==== hw/boot_loader.sv ====
`timescale 1ns/1ps

module boot_loader import board_pkg::*, axil_pkg::*; (
    input  logic     clk50,
    input  logic     rst,

    output logic     aw_valid,
    input  logic     aw_ready,
    output axil_aw_t aw,

    output logic     w_valid,
    input  logic     w_ready,
    output axil_w_t  w,

    input  logic     b_valid,
    output logic     b_ready,
    input  axil_b_t  b,

    output logic     boot_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_RESP,
        ST_DONE
    } state_t;

    state_t                state_q;
    logic [BOOT_IDX_W-1:0] word_q;
    logic                  aw_valid_q;
    logic                  w_valid_q;
    logic                  aw_left;
    logic                  w_left;

    // Channel still owes a handshake after this edge
    assign aw_left = aw_valid_q && !aw_ready;
    assign w_left  = w_valid_q && !w_ready;

    always_ff @(posedge clk50) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            word_q     <= '0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            boot_done  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    aw_valid_q <= 1'b1;
                    w_valid_q  <= 1'b1;
                    state_q    <= ST_SEND;
                end
                ST_SEND: begin
                    if (aw_ready) aw_valid_q <= 1'b0;
                    if (w_ready) w_valid_q <= 1'b0;
                    if (!aw_left && !w_left) state_q <= ST_RESP;
                end
                ST_RESP: begin
                    if (b_valid) begin
                        if (b.resp != RESP_OKAY) begin  // Resend the same word
                            aw_valid_q <= 1'b1;
                            w_valid_q  <= 1'b1;
                            state_q    <= ST_SEND;
                        end else if (word_q == BOOT_IDX_W'(BOOT_WORDS - 1)) begin
                            boot_done <= 1'b1;
                            state_q   <= ST_DONE;
                        end else begin
                            word_q     <= word_q + 1'b1;
                            aw_valid_q <= 1'b1;
                            w_valid_q  <= 1'b1;
                            state_q    <= ST_SEND;
                        end
                    end
                end
                default: ;  // ST_DONE holds until reset
            endcase
        end
    end

    always_comb begin
        aw.addr = word_addr(word_q);
        aw.prot = 3'b000;
        for (int k = 0; k < WORD_BYTES; k++) begin
            w.data[8*k +: 8] = boot_byte(word_q, k);
        end
        w.strb = '1;  // Full word writes only
    end

    assign aw_valid = aw_valid_q;
    assign w_valid  = w_valid_q;
    assign b_ready  = (state_q == ST_RESP);

endmodule

// ==== hw/mem_viewer.sv ====
`timescale 1ns/1ps

module mem_viewer import board_pkg::*, axil_pkg::*; (
    input  logic       clk50,
    input  logic       rst,
    input  logic       boot_done,
    input  logic       btnd,
    input  logic [7:0] sw,

    output logic       ar_valid,
    input  logic       ar_ready,
    output axil_ar_t   ar,

    input  logic       r_valid,
    output logic       r_ready,
    input  axil_r_t    r,

    output logic [7:0] led,
    output logic       view_busy
);

    logic [2:0] btnd_q;  // Two sync flops plus edge history
    logic       btnd_rise;
    logic [5:0] sel_q;   // Byte in [5:4], word in [3:0]
    logic       ar_valid_q;
    logic       start;

    assign btnd_rise = btnd_q[1] && !btnd_q[2];
    assign start     = btnd_rise && boot_done && !view_busy;

    always_ff @(posedge clk50) begin
        if (rst) begin
            btnd_q     <= '0;
            ar_valid_q <= 1'b0;
            view_busy  <= 1'b0;
            led        <= '0;
        end else begin
            btnd_q <= {btnd_q[1:0], btnd};
            if (start) begin
                view_busy  <= 1'b1;
                ar_valid_q <= 1'b1;
            end else if (ar_valid_q && ar_ready) begin
                ar_valid_q <= 1'b0;
            end
            if (r_valid && r_ready) begin
                if (r.resp == RESP_OKAY) begin
                    led       <= r.data[8*sel_q[5:4] +: 8];
                    view_busy <= 1'b0;
                end else begin
                    ar_valid_q <= 1'b1;  // Retry the read
                end
            end
        end
    end

    always_ff @(posedge clk50) begin
        if (start) sel_q <= sw[5:0];
    end

    assign ar_valid = ar_valid_q;
    assign ar.addr  = word_addr(sel_q[3:0]);
    assign ar.prot  = 3'b000;
    assign r_ready  = view_busy && !ar_valid_q;

endmodule

// ==== hw/nexys_boot_top.sv ====
`timescale 1ns/1ps

module nexys_boot_top import axil_pkg::*; (
    input  logic       clk50,
    input  logic       cpu_resetn,
    input  logic       btnc,
    input  logic       btnd,
    input  logic [7:0] sw,
    output logic [7:0] led,
    output logic       boot_done,
    output logic       pause_ack,
    output logic       view_busy
);

    logic rst;
    logic pause_req;

    logic     aw_valid, aw_ready;
    logic     w_valid, w_ready;
    logic     b_valid, b_ready;
    logic     ar_valid, ar_ready;
    logic     r_valid, r_ready;
    axil_aw_t aw;
    axil_w_t  w;
    axil_b_t  b;
    axil_ar_t ar;
    axil_r_t  r;

    sys_ctrl u_sys_ctrl (
        .clk50      (clk50),
        .cpu_resetn (cpu_resetn),
        .btnc       (btnc),
        .rst        (rst),
        .pause_req  (pause_req)
    );

    // Write channels only
    boot_loader u_boot_loader (
        .clk50     (clk50),
        .rst       (rst),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .boot_done (boot_done)
    );

    axil_ram u_axil_ram (
        .clk50     (clk50),
        .rst       (rst),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r)
    );

    // Read channels only
    mem_viewer u_mem_viewer (
        .clk50     (clk50),
        .rst       (rst),
        .boot_done (boot_done),
        .btnd      (btnd),
        .sw        (sw),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .led       (led),
        .view_busy (view_busy)
    );

endmodule

// ==== hw/skid_buffer.sv ====
`timescale 1ns/1ps

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk50,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     out_valid_q;
    logic     skid_valid_q;
    payload_t out_data_q;
    payload_t skid_data_q;

    logic out_free;
    logic load_out;
    logic load_skid;

    assign in_ready  = !skid_valid_q;  // Registered, no path from out_ready
    assign out_free  = out_ready || !out_valid_q;
    assign load_out  = out_free && (skid_valid_q || in_valid);
    assign load_skid = in_valid && in_ready && !out_free;

    always_ff @(posedge clk50) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            out_valid_q  <= skid_valid_q || in_valid;
            skid_valid_q <= 1'b0;
        end else if (load_skid) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk50) begin
        if (load_out) out_data_q <= skid_valid_q ? skid_data_q : in_data;
        if (load_skid) skid_data_q <= in_data;
    end

    assign out_valid = out_valid_q;
    assign out_data  = out_data_q;

endmodule

// ==== hw/sys_ctrl.sv ====
`timescale 1ns/1ps

module sys_ctrl import board_pkg::*; (
    input  logic clk50,
    input  logic cpu_resetn,
    input  logic btnc,
    output logic rst,
    output logic pause_req
);

    logic [RESET_CNT_W-1:0] count_q;
    logic [1:0]             btnc_q;

    // Reset stretch, rst drops RESET_CYCLES edges after the button is released
    always_ff @(posedge clk50) begin
        if (!cpu_resetn) begin
            count_q <= '0;
            rst     <= 1'b1;
        end else begin
            if (count_q == RESET_CNT_W'(RESET_CYCLES)) begin
                rst <= 1'b0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // Two flop synchronizer for the pause button
    always_ff @(posedge clk50) begin
        if (!cpu_resetn) begin
            btnc_q <= '0;
        end else begin
            btnc_q <= {btnc_q[0], btnc};
        end
    end

    assign pause_req = btnc_q[1];

endmodule

// ==== src.f ====
hw/board_pkg.sv
hw/axil_pkg.sv
hw/sys_ctrl.sv
hw/skid_buffer.sv
hw/boot_loader.sv
hw/axil_ram.sv
hw/mem_viewer.sv
hw/nexys_boot_top.sv
dv/axil_checker.sv
dv/tb_clk_gen.sv
dv/tb_top.sv
